// ==== bench/loopFilter_asserts.sv ====
`default_nettype none

module loopFilterAsserts (
    input  logic                clk,
    input  logic                reset,
    input  logic                clkEn,
    input  logic                cfgWrite,
    input  logic [1:0]          cfgAddr,
    input  logic [31:0]         cfgData,
    input  logic                freqValid,
    input  logic signed [39:0]  lagAccum
);

    logic [31:0] lim;   // shadow of the LIMIT register

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lim <= '0;
        end else if (cfgWrite && cfgAddr == 2'd1) begin
            lim <= cfgData;
        end
    end

    // strobe edge, then summer register one cycle later
    validAfterStrobe: assert property (@(posedge clk) disable iff (reset)
        $past(clkEn, 2) |-> freqValid) else $error("freqValid missing after strobe");

    noStrayValid: assert property (@(posedge clk) disable iff (reset)
        freqValid |-> $past(clkEn, 2)) else $error("freqValid without strobe");

    accumInBounds: assert property (@(posedge clk) disable iff (reset)
        clkEn |=> (longint'(lagAccum) <= longint'($past(lim)) * 256 + 255
               && longint'(lagAccum) >= -(longint'($past(lim)) * 256) - 255))
        else $error("lagAccum outside limit");

endmodule

`default_nettype wire

// ==== bench/loopFilter_tb.sv ====
`default_nettype none

`include "loopFilter_defines.svh"

module loopFilter_tb;

    logic                   clk;
    logic                   reset;
    logic                   clkEn;
    loopDataPkg::error_t    error;
    logic                   carrierInSync;
    logic                   cfgWrite;
    logic [`LF_ADDR_W-1:0]  cfgAddr;
    logic [`LF_FREQ_W-1:0]  cfgData;
    loopDataPkg::freq_t     freqWord;
    logic                   freqValid;
    loopDataPkg::accum_t    lagAccum;

    // reference model state
    logic [4:0]         mLeadExp, mLagExp;
    logic [31:0]        mLimit, mSweepMag;
    logic               mSweepEn, mClear, mSampleDone, mValid;
    logic signed [39:0] mLead, mLagTerm, mAcc;
    logic signed [31:0] mOff, mDir, mFreq;

    int failCount;
    int timeoutCount;
    int topHits, bottomHits;
    logic signed [39:0] heldAcc;

    loopFilter loopFilter_i (.*);

    bind loopFilter loopFilterAsserts loopFilterAssertsI (
        .clk(clk), .reset(reset), .clkEn(clkEn), .cfgWrite(cfgWrite), .cfgAddr(cfgAddr),
        .cfgData(cfgData), .freqValid(freqValid), .lagAccum(lagAccum)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // error times 2^(k+1), sign copied into the freed low bits
    function automatic logic signed [39:0] refScale(input logic signed [7:0] e,
                                                    input logic [4:0] k);
        logic signed [39:0] r;
        int sh;
        sh = int'(k) + 1;
        if (k == 5'd0) return '0;
        r = 40'(e) <<< sh;
        if (e < 0) r = r | ((40'sd1 <<< sh) - 40'sd1);
        return r;
    endfunction

    function automatic logic signed [31:0] refSat(input logic signed [39:0] a,
                                                  input logic signed [39:0] b);
        longint t;
        t = longint'(a) + longint'(b);
        if (t > 64'sh7F_FFFF_FFFF) return 32'sh7FFF_FFFF;
        if (t < -64'sh80_0000_0000) return 32'sh8000_0000;
        return 32'(t >>> 8);
    endfunction

    function automatic logic [31:0] ctrlWord(input logic [4:0] lead, input logic [4:0] lag,
                                             input logic sweep, input logic clr);
        return {7'd0, clr, 7'd0, sweep, 3'd0, lag, 3'd0, lead};
    endfunction

    always @(posedge clk or posedge reset) begin : model
        logic signed [39:0] sum;
        logic signed [31:0] top;
        logic signed [31:0] lim;
        logic               allowed;
        if (reset) begin
            {mLeadExp, mLagExp, mLimit, mSweepMag, mSweepEn, mClear} <= '0;
            {mSampleDone, mValid, mLead, mLagTerm, mAcc, mOff, mDir, mFreq} <= '0;
        end else begin
            sum = mAcc + mLagTerm + 40'(mOff);
            top = sum[39:8];
            lim = mLimit;
            allowed = !carrierInSync && mSweepEn;
            mValid <= mSampleDone;
            if (mSampleDone) mFreq <= refSat(mLead, mAcc);
            mSampleDone <= clkEn;
            if (clkEn) begin
                mLead <= refScale(error, mLeadExp);
                mLagTerm <= refScale(error, mLagExp);
            end
            if (mClear) begin
                mAcc <= '0;
            end else if (clkEn) begin
                if (top >= lim) begin
                    mAcc <= {lim, 8'h00};
                    mOff <= allowed ? -mSweepMag : 32'sd0;
                    if (allowed) mDir <= -mSweepMag;
                end else if (top < -lim) begin
                    mAcc <= {-lim, 8'hFF};
                    mOff <= allowed ? mSweepMag : 32'sd0;
                    if (allowed) mDir <= mSweepMag;
                end else begin
                    mAcc <= sum;
                    mOff <= allowed ? mDir : 32'sd0;
                    if (mDir == 0) mDir <= mSweepMag;
                end
            end
            mClear <= 1'b0;
            if (cfgWrite) begin
                case (cfgAddr)
                    2'd0: begin
                        {mLeadExp, mLagExp, mSweepEn} <= {cfgData[4:0], cfgData[12:8], cfgData[16]};
                        mClear <= cfgData[24];
                    end
                    2'd1: mLimit <= cfgData;
                    2'd2: mSweepMag <= cfgData;
                    default: ;
                endcase
            end
        end
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic checkValue(input string name, input logic [39:0] exp, input logic [39:0] act);
        assert (exp === act) else begin
            failCount++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic writeReg(input logic [1:0] addr, input logic [31:0] data);
        cfgWrite = 1'b1;
        cfgAddr = addr;
        cfgData = data;
        tick();
        cfgWrite = 1'b0;
    endtask

    // wait for the valid pulse, then check each cycle while it stays high
    task automatic checkResults(input string name);
        int n;
        n = 0;
        while (!freqValid && n < 20) begin
            tick();
            n++;
        end
        assert (freqValid) else begin
            timeoutCount++;
            $display("timeout: freqValid never came in test %s", name);
        end
        n = 0;
        while (freqValid && n < 40) begin
            checkValue({name, " freqValid"}, 40'(mValid), 40'(freqValid));
            checkValue({name, " freqWord"}, 40'(mFreq), 40'(freqWord));
            checkValue({name, " lagAccum"}, mAcc, lagAccum);
            tick();
            n++;
        end
    endtask

    task automatic strobe(input string name, input int count, input logic signed [7:0] e,
                          input logic randomErr);
        for (int i = 0; i < count; i++) begin
            clkEn = 1'b1;
            error = randomErr ? 8'($urandom) : e;
            tick();
        end
        clkEn = 1'b0;
        checkResults(name);
    endtask

    initial begin
        logic [4:0] k;
        void'($urandom(92789));
        {clkEn, error, cfgWrite, cfgAddr, cfgData} = '0;
        carrierInSync = 1'b1;
        failCount = 0;
        timeoutCount = 0;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;

        writeReg(2'd1, 32'h4000_0000);
        for (int i = 0; i < 24; i++) begin
            k = (i == 0) ? 5'd0 : (i < 3) ? 5'd31 : 5'($urandom);
            writeReg(2'd0, ctrlWord(k, 5'd0, 1'b0, 1'b0));
            strobe("lead", 1, -8'sd100 - 8'(i), i > 2);
        end

        writeReg(2'd0, ctrlWord(5'd0, 5'($urandom_range(12, 1)), 1'b0, 1'b0));
        for (int i = 0; i < 30; i++) strobe("integrate", 1, 8'sd0, 1'b1);

        writeReg(2'd1, 32'd3);
        writeReg(2'd0, ctrlWord(5'd0, 5'd20, 1'b0, 1'b0));
        strobe("clampHigh", 10, 8'sd100, 1'b0);
        checkValue("clampHigh bound", {32'd3, 8'h00}, lagAccum);
        strobe("clampLow", 10, -8'sd100, 1'b0);
        checkValue("clampLow bound", {-32'sd3, 8'hFF}, lagAccum);

        writeReg(2'd1, 32'd4);
        writeReg(2'd2, 32'd300);
        writeReg(2'd0, ctrlWord(5'd0, 5'd0, 1'b1, 1'b1));
        carrierInSync = 1'b0;
        topHits = 0;
        bottomHits = 0;
        for (int i = 0; i < 40; i++) begin
            strobe("sweep", 1, 8'sd0, 1'b0);
            if (lagAccum == {32'd4, 8'h00}) topHits++;
            if (lagAccum == {-32'sd4, 8'hFF}) bottomHits++;
        end
        assert (topHits > 1 && bottomHits > 1) else begin
            failCount++;
            $display("sweep did not alternate between both limits");
        end
        carrierInSync = 1'b1;
        strobe("sweepStop", 2, 8'sd0, 1'b0);
        heldAcc = mAcc;
        strobe("sweepStop", 3, 8'sd0, 1'b0);
        checkValue("sweepStop hold", heldAcc, lagAccum);

        writeReg(2'd1, 32'h0010_0000);
        writeReg(2'd0, ctrlWord(5'd0, 5'd10, 1'b0, 1'b0));
        strobe("preClear", 5, 8'sd90, 1'b0);
        writeReg(2'd0, ctrlWord(5'd0, 5'd10, 1'b0, 1'b1));
        strobe("clear", 1, 8'sd50, 1'b0);
        checkValue("clear zero", 40'd0, lagAccum);
        strobe("resume", 10, 8'sd0, 1'b1);

        for (int i = 0; i < 200; i++) begin
            carrierInSync = 1'($urandom);
            case ($urandom_range(5, 0))
                0: writeReg(2'd0, ctrlWord(5'($urandom_range(31, 20)), 5'($urandom_range(31, 20)),
                                           1'($urandom), ($urandom_range(9, 0) == 0)));
                1: writeReg(2'd1, $urandom_range(32'h4000_0000, 1));
                2: writeReg(2'd2, $urandom_range(32'hFFFF, 0));
                3: writeReg(2'd3, $urandom);
                default: strobe("mix", $urandom_range(3, 1), 8'sd0, 1'b1);
            endcase
        end

        $display("errors: %0d mismatches, %0d timeouts", failCount, timeoutCount);
        if (failCount == 0 && timeoutCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hdl
hdl/loopRegPkg.sv
hdl/loopDataPkg.sv
hdl/loopCtrlIf.sv
hdl/loopRegs.sv
hdl/leadGain.sv
hdl/lagGain.sv
hdl/loopSum.sv
hdl/loopFilter.sv
bench/loopFilter_asserts.sv
bench/loopFilter_tb.sv

// ==== hdl/lagGain.sv ====
`default_nettype none

`include "loopFilter_defines.svh"

module lagGain (
    input  logic                clk,
    input  logic                reset,
    input  logic                clkEn,
    input  loopDataPkg::error_t error,
    input  logic                carrierInSync,
    loopCtrlIf.lag              ctrl,
    output loopDataPkg::accum_t lagAccum
);

    localparam int PAD_W = `LF_ACC_W - `LF_FREQ_W;

    loopDataPkg::term_t           lagTerm;      // one sample behind the error
    loopDataPkg::accum_t          sum;
    logic signed [`LF_FREQ_W-1:0] sweepOffset;
    logic signed [`LF_FREQ_W-1:0] sweepMag;     // sign sets sweep direction
    logic signed [`LF_FREQ_W-1:0] upperLimit;
    logic signed [`LF_FREQ_W-1:0] lowerLimit;
    logic signed [`LF_FREQ_W-1:0] negMag;
    logic signed [`LF_FREQ_W-1:0] sumTop;
    logic                         atUpper;
    logic                         atLower;
    logic                         sweepAllowed;

    assign upperLimit   = ctrl.limit;
    assign lowerLimit   = -ctrl.limit;
    assign negMag       = -ctrl.sweepOffsetMag;
    assign sweepAllowed = !carrierInSync && ctrl.sweepEnable;

    assign sum = lagAccum + lagTerm + {{PAD_W{sweepOffset[`LF_FREQ_W-1]}}, sweepOffset};

    // integer part decides the clamp
    assign sumTop  = sum[`LF_ACC_W-1:PAD_W];
    assign atUpper = sumTop >= upperLimit;
    assign atLower = sumTop < lowerLimit;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lagTerm <= '0;
        end else if (clkEn) begin
            lagTerm <= loopDataPkg::scaleError(error, ctrl.lagExp);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lagAccum    <= '0;
            sweepOffset <= '0;
            sweepMag    <= '0;
        end else if (ctrl.clearAccum) begin
            lagAccum <= '0;     // wins over a strobe in the same cycle
        end else if (clkEn) begin
            if (atUpper) begin
                lagAccum <= {upperLimit, {PAD_W{1'b0}}};
                if (sweepAllowed) begin
                    sweepOffset <= negMag;  // turn the sweep downward
                    sweepMag    <= negMag;
                end else begin
                    sweepOffset <= '0;
                end
            end else if (atLower) begin
                lagAccum <= {lowerLimit, {PAD_W{1'b1}}};
                if (sweepAllowed) begin
                    sweepOffset <= ctrl.sweepOffsetMag;
                    sweepMag    <= ctrl.sweepOffsetMag;
                end else begin
                    sweepOffset <= '0;
                end
            end else begin
                lagAccum    <= sum;
                sweepOffset <= sweepAllowed ? sweepMag : '0;
                if (sweepMag == '0) begin
                    sweepMag <= ctrl.sweepOffsetMag;   // first step after reset
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/leadGain.sv ====
`default_nettype none

module leadGain (
    input  logic                clk,
    input  logic                reset,
    input  logic                clkEn,
    input  loopDataPkg::error_t error,
    loopCtrlIf.lead             ctrl,
    output loopDataPkg::term_t  leadTerm,
    output logic                sampleDone
);

    // proportional path
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            leadTerm <= '0;
        end else if (clkEn) begin
            leadTerm <= loopDataPkg::scaleError(error, ctrl.leadExp);
        end
    end

    // strobe copy, marks fresh lead and lag values for the summer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sampleDone <= 1'b0;
        end else begin
            sampleDone <= clkEn;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/loopCtrlIf.sv ====
`default_nettype none

`include "loopFilter_defines.svh"

interface loopCtrlIf;

    logic [`LF_EXP_W-1:0]   leadExp;
    logic [`LF_EXP_W-1:0]   lagExp;
    logic [`LF_FREQ_W-1:0]  limit;
    logic                   sweepEnable;
    logic [`LF_FREQ_W-1:0]  sweepOffsetMag;
    logic                   clearAccum;     // one cycle pulse

    modport regs (
        output leadExp,
        output lagExp,
        output limit,
        output sweepEnable,
        output sweepOffsetMag,
        output clearAccum
    );

    modport lead (
        input leadExp
    );

    modport lag (
        input lagExp,
        input limit,
        input sweepEnable,
        input sweepOffsetMag,
        input clearAccum
    );

endinterface

`default_nettype wire

// ==== hdl/loopDataPkg.sv ====
`default_nettype none

`include "loopFilter_defines.svh"

package loopDataPkg;

    typedef logic signed [`LF_ERR_W-1:0]  error_t;
    typedef logic signed [`LF_ACC_W-1:0]  term_t;
    typedef logic signed [`LF_ACC_W-1:0]  accum_t;    // 32 integer, 8 fraction
    typedef logic signed [`LF_FREQ_W-1:0] freq_t;

    // error scaled by 2^(k+1), low bits filled with the sign, zero for k == 0
    function automatic term_t scaleError(input error_t err, input logic [`LF_EXP_W-1:0] k);
        term_t ext;
        term_t fill;
        ext = {{(`LF_ACC_W-`LF_ERR_W){err[`LF_ERR_W-1]}}, err};
        fill = {`LF_ACC_W{err[`LF_ERR_W-1]}};
        if (k == '0) begin
            return '0;
        end
        return (ext <<< (k + 1)) | (fill >> (`LF_ACC_W - 1 - k));
    endfunction

endpackage

`default_nettype wire

// ==== hdl/loopFilter.sv ====
`default_nettype none

`include "loopFilter_defines.svh"

module loopFilter (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    clkEn,
    input  loopDataPkg::error_t     error,
    input  logic                    carrierInSync,
    input  logic                    cfgWrite,
    input  logic [`LF_ADDR_W-1:0]   cfgAddr,
    input  logic [`LF_FREQ_W-1:0]   cfgData,
    output loopDataPkg::freq_t      freqWord,
    output logic                    freqValid,
    output loopDataPkg::accum_t     lagAccum
);

    loopDataPkg::term_t leadTerm;
    logic               sampleDone;

    loopCtrlIf ctrlBus ();

    loopRegs loopRegsI (
        .clk      (clk),
        .reset    (reset),
        .cfgWrite (cfgWrite),
        .cfgAddr  (cfgAddr),
        .cfgData  (cfgData),
        .ctrl     (ctrlBus.regs)
    );

    leadGain leadGainI (
        .clk        (clk),
        .reset      (reset),
        .clkEn      (clkEn),
        .error      (error),
        .ctrl       (ctrlBus.lead),
        .leadTerm   (leadTerm),
        .sampleDone (sampleDone)
    );

    lagGain lagGainI (
        .clk           (clk),
        .reset         (reset),
        .clkEn         (clkEn),
        .error         (error),
        .carrierInSync (carrierInSync),
        .ctrl          (ctrlBus.lag),
        .lagAccum      (lagAccum)
    );

    // lead and lag meet here
    loopSum loopSumI (
        .clk        (clk),
        .reset      (reset),
        .sampleDone (sampleDone),
        .leadTerm   (leadTerm),
        .lagAccum   (lagAccum),
        .freqWord   (freqWord),
        .freqValid  (freqValid)
    );

endmodule

`default_nettype wire

// ==== hdl/loopFilter_defines.svh ====
`ifndef LOOPFILTER_DEFINES_SVH
`define LOOPFILTER_DEFINES_SVH

// datapath widths
`define LF_ERR_W    8
`define LF_ACC_W    40
`define LF_FREQ_W   32
`define LF_EXP_W    5

// register port
`define LF_ADDR_W   2

`define LF_REG_CTRL     2'd0
`define LF_REG_LIMIT    2'd1    // clamp level, integer part
`define LF_REG_SWEEP    2'd2    // sweep step magnitude

`endif

// ==== hdl/loopRegPkg.sv ====
`default_nettype none

`include "loopFilter_defines.svh"

package loopRegPkg;

    // CTRL register layout
    typedef struct packed {
        logic [6:0]             rsvd31;
        logic                   clearAccum;     // bit 24, self clearing
        logic [6:0]             rsvd23;
        logic                   sweepEnable;    // bit 16
        logic [2:0]             rsvd15;
        logic [`LF_EXP_W-1:0]   lagExp;         // bits 12..8
        logic [2:0]             rsvd7;
        logic [`LF_EXP_W-1:0]   leadExp;        // bits 4..0
    } ctrlFields_t;

    // one write word, read as fields for CTRL or as a number for LIMIT and SWEEP
    typedef union packed {
        ctrlFields_t            fields;
        logic [`LF_FREQ_W-1:0]  magnitude;
    } cfgWord_t;

endpackage

`default_nettype wire

// ==== hdl/loopRegs.sv ====
`default_nettype none

`include "loopFilter_defines.svh"

module loopRegs (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cfgWrite,
    input  logic [`LF_ADDR_W-1:0]   cfgAddr,
    input  logic [`LF_FREQ_W-1:0]   cfgData,
    loopCtrlIf.regs                 ctrl
);

    loopRegPkg::cfgWord_t cfgWord;

    assign cfgWord = cfgData;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrl.leadExp        <= '0;
            ctrl.lagExp         <= '0;
            ctrl.limit          <= '0;
            ctrl.sweepEnable    <= 1'b0;
            ctrl.sweepOffsetMag <= '0;
            ctrl.clearAccum     <= 1'b0;
        end else begin
            ctrl.clearAccum <= 1'b0;    // drops again after one cycle
            if (cfgWrite) begin
                case (cfgAddr)
                    `LF_REG_CTRL: begin
                        ctrl.leadExp     <= cfgWord.fields.leadExp;
                        ctrl.lagExp      <= cfgWord.fields.lagExp;
                        ctrl.sweepEnable <= cfgWord.fields.sweepEnable;
                        ctrl.clearAccum  <= cfgWord.fields.clearAccum;
                    end
                    `LF_REG_LIMIT: begin
                        ctrl.limit <= cfgWord.magnitude;
                    end
                    `LF_REG_SWEEP: begin
                        ctrl.sweepOffsetMag <= cfgWord.magnitude;
                    end
                    default: begin
                        // address 3 unmapped, write ignored
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/loopSum.sv ====
`default_nettype none

`include "loopFilter_defines.svh"

module loopSum (
    input  logic                clk,
    input  logic                reset,
    input  logic                sampleDone,
    input  loopDataPkg::term_t  leadTerm,
    input  loopDataPkg::accum_t lagAccum,
    output loopDataPkg::freq_t  freqWord,
    output logic                freqValid
);

    localparam int PAD_W = `LF_ACC_W - `LF_FREQ_W;

    logic signed [`LF_ACC_W:0]  total;      // one guard bit
    logic                       overflow;
    loopDataPkg::freq_t         satWord;

    assign total = {leadTerm[`LF_ACC_W-1], leadTerm} + {lagAccum[`LF_ACC_W-1], lagAccum};

    // guard and sign disagree when the integer part leaves 32 bits
    assign overflow = total[`LF_ACC_W] != total[`LF_ACC_W-1];

    always_comb begin
        if (!overflow) begin
            satWord = total[`LF_ACC_W-1:PAD_W];
        end else if (total[`LF_ACC_W]) begin
            satWord = {1'b1, {(`LF_FREQ_W-1){1'b0}}};   // most negative
        end else begin
            satWord = {1'b0, {(`LF_FREQ_W-1){1'b1}}};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            freqWord <= '0;
        end else if (sampleDone) begin
            freqWord <= satWord;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            freqValid <= 1'b0;
        end else begin
            freqValid <= sampleDone;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f flist.f --top-module loopFilter_tb -o simv

out=$(./obj_dir/simv)
echo "$out"

if echo "$out" | grep -q "Done: no errors"; then
    exit 0
else
    exit 1
fi
